// File: verilog.f
src/fetch_pkg.sv
src/icache.sv
src/dmem_reader.sv
src/read_arbiter.sv
src/fetch_top.sv
bench/burst_mem.sv
bench/fetch_props.sv
bench/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - src/fetch_pkg.sv
  - src/icache.sv
  - src/dmem_reader.sv
  - src/read_arbiter.sv
  - src/fetch_top.sv
  - target: test
    files:
      - bench/burst_mem.sv
      - bench/fetch_props.sv
      - bench/tb_fetch.sv

// File: bench/tb_fetch.sv
`default_nettype none

module tb_fetch;
	import fetch_pkg::*;

	localparam int wait_limit = 100;  // cycles per transfer

	logic                    clock;
	logic                    reset;
	logic                    fetch_valid;
	logic [addr_width-1:0]   fetch_addr;
	logic                    fetch_ready;
	logic [xlen-1:0]         fetch_data;
	logic                    fence;
	logic                    load_valid;
	logic [addr_width-1:0]   load_addr;
	logic                    load_ready;
	logic [xlen-1:0]         load_data;
	logic                    mem_valid;
	logic [addr_width-1:0]   mem_addr;
	logic [len_width-1:0]    mem_len;
	logic                    mem_ready;
	logic [xlen-1:0]         mem_data;
	logic                    mem_last;

	logic [31:0] rng_q;
	int          checks;
	int          errors;
	int          checks_at_start;
	int          errors_at_start;
	string       test_name;

	// lines known to sit in the cache, the latest refill of each set
	logic [31:0] shadow_line [1 << index_bits];
	bit          shadow_valid [1 << index_bits];

	fetch_top UUT (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid),
		.fetch_addr_i  (fetch_addr),
		.fetch_ready_o (fetch_ready),
		.fetch_data_o  (fetch_data),
		.fence_i       (fence),
		.load_valid_i  (load_valid),
		.load_addr_i   (load_addr),
		.load_ready_o  (load_ready),
		.load_data_o   (load_data),
		.mem_valid_o   (mem_valid),
		.mem_addr_o    (mem_addr),
		.mem_len_o     (mem_len),
		.mem_ready_i   (mem_ready),
		.mem_data_i    (mem_data),
		.mem_last_i    (mem_last)
	);

	burst_mem u_mem (
		.clock       (clock),
		.reset       (reset),
		.mem_valid_i (mem_valid),
		.mem_addr_i  (mem_addr),
		.mem_len_i   (mem_len),
		.mem_ready_o (mem_ready),
		.mem_data_o  (mem_data),
		.mem_last_o  (mem_last)
	);

	always #20 clock = ~clock;

	function automatic logic [31:0] next_rand();
		rng_q = rng_q * 32'd1664525 + 32'd1013904223;
		return rng_q;
	endfunction

	function automatic logic [31:0] word_of(input logic [31:0] a);
		return ((a ^ 32'h2545f491) * 32'h9e3779b1) ^ (a >> 13);
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		$display("test %s done: %0d checks, %0d errors", test_name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
		$display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
		errors++;
	endtask

	task automatic clear_shadow();
		for (int s = 0; s < (1 << index_bits); s++) begin
			shadow_valid[s] = 1'b0;
		end
	endtask

	task automatic pulse_fence();
		@(posedge clock);
		fence <= 1'b1;
		@(posedge clock);
		fence <= 1'b0;
		clear_shadow();
	endtask

	// a hit shows ready on the second sampled cycle, a miss always later
	task automatic fetch_word(input logic [31:0] addr, input bit lone, input bit want_miss);
		logic [31:0]            line;
		logic [index_bits-1:0]  set;
		logic [31:0]            got;
		logic [31:0]            bus_addr;
		logic [len_width-1:0]   bus_len;
		bit                     expect_hit;
		bit                     bus_seen;
		bit                     done;
		int                     cycles;
		line = {addr[31:4], 4'h0};
		set = addr[11:4];
		expect_hit = shadow_valid[set] && (shadow_line[set] == line);
		bus_seen = 1'b0;
		bus_addr = '0;
		bus_len = '0;
		done = 1'b0;
		cycles = 0;
		@(posedge clock);
		fetch_valid <= 1'b1;
		fetch_addr  <= addr;
		while (!done && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
			if (mem_valid && !bus_seen) begin
				bus_seen = 1'b1;
				bus_addr = mem_addr;
				bus_len = mem_len;
			end
			done = fetch_ready;
		end
		got = fetch_data;
		@(posedge clock);
		fetch_valid <= 1'b0;
		if (!done) begin
			$display("timeout: fetch from %h got no ready within %0d cycles", addr, wait_limit);
			errors++;
		end else begin
			checks++;
			if (got !== word_of({addr[31:2], 2'b00})) report_mismatch(word_of({addr[31:2], 2'b00}), got);
			if (expect_hit && cycles != 2) report_mismatch(32'd1, cycles - 1);  // latency
			if (want_miss && cycles == 2) begin
				$display("%s: fetch from %h hit a line that was not cached", test_name, addr);
				errors++;
			end
			if (lone && cycles == 2 && bus_seen) begin
				$display("%s: bus read seen during a hit at %h", test_name, addr);
				errors++;
			end
			if (lone && cycles != 2) begin
				if (bus_addr !== line) report_mismatch(line, bus_addr);
				if (bus_len !== line_burst_len) report_mismatch(line_burst_len, bus_len);
			end
			if (cycles != 2) begin
				shadow_line[set] = line;
				shadow_valid[set] = 1'b1;
			end
		end
	endtask

	task automatic load_word(input logic [31:0] addr, input bit lone);
		logic [31:0]            got;
		logic [31:0]            bus_addr;
		logic [len_width-1:0]   bus_len;
		bit                     bus_seen;
		bit                     done;
		int                     cycles;
		bus_seen = 1'b0;
		bus_addr = '0;
		bus_len = '1;
		done = 1'b0;
		cycles = 0;
		@(posedge clock);
		load_valid <= 1'b1;
		load_addr  <= addr;
		while (!done && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
			if (mem_valid && !bus_seen) begin
				bus_seen = 1'b1;
				bus_addr = mem_addr;
				bus_len = mem_len;
			end
			done = load_ready;
		end
		got = load_data;
		@(posedge clock);
		load_valid <= 1'b0;
		if (!done) begin
			$display("timeout: load from %h got no ready within %0d cycles", addr, wait_limit);
			errors++;
		end else begin
			checks++;
			if (got !== word_of(addr)) report_mismatch(word_of(addr), got);
			if (lone && bus_addr !== addr) report_mismatch(addr, bus_addr);
			if (lone && bus_len !== word_burst_len) report_mismatch(word_burst_len, bus_len);
		end
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] line_addr [16];
		logic [31:0] conflict_line [6];
		int          total;
		rng_q = 32'd34;
		checks = 0;
		errors = 0;
		clock = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		fence = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		clear_shadow();
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		start_test("miss_refill");
		for (int i = 0; i < 16; i++) begin
			a = next_rand();
			line_addr[i] = {a[31:12], 8'(i * 13), a[3:2], 2'b00};  // one set each
			fetch_word(line_addr[i], 1'b1, 1'b1);
		end
		finish_test();

		start_test("hit");
		for (int i = 0; i < 16; i++) begin
			a = next_rand();
			fetch_word({line_addr[i][31:4], a[3:2], 2'b00}, 1'b1, 1'b0);
		end
		finish_test();

		start_test("fence");
		pulse_fence();
		for (int i = 0; i < 8; i++) begin
			fetch_word(line_addr[i], 1'b1, 1'b1);
		end
		finish_test();

		start_test("data_load");
		for (int i = 0; i < 16; i++) begin
			a = next_rand();
			load_word({a[31:2], 2'b00}, 1'b1);
		end
		finish_test();

		start_test("contention");
		for (int i = 0; i < 40; i++) begin
			a = next_rand();
			b = next_rand();
			fork
				fetch_word({a[31:2], 2'b00}, 1'b0, 1'b0);
				load_word({b[31:2], 2'b00}, 1'b0);
			join
		end
		finish_test();

		start_test("set_conflict");
		for (int i = 0; i < 6; i++) begin
			a = next_rand();
			conflict_line[i] = {a[31:12], 8'ha5, 4'h0};
		end
		for (int i = 0; i < 36; i++) begin
			a = next_rand();
			fetch_word({conflict_line[a[15:8] % 6][31:4], a[3:2], 2'b00}, 1'b1, 1'b0);
		end
		finish_test();

		total = errors + UUT.u_fetch_props.fail_count;
		$display("checks %0d, errors %0d", checks, total);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/fetch_props.sv
`default_nettype none

module fetch_props (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               mem_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   mem_addr_i,
	input  logic                               mem_ready_i,
	input  logic                               mem_last_i,
	input  logic                               ic_ready_i,
	input  logic                               dr_ready_i,
	input  logic                               fetch_ready_i
);
	int   fail_count = 0;
	logic ic_open_q;  // cache burst started and not yet finished

	always_ff @(posedge clock) begin
		if (reset) begin
			ic_open_q <= 1'b0;
		end else if (ic_ready_i) begin
			ic_open_q <= !mem_last_i;
		end
	end

	// request held with the same address until the final beat
	bus_held: assert property (@(posedge clock) disable iff (reset)
		mem_valid_i && !(mem_ready_i && mem_last_i) |=> mem_valid_i && $stable(mem_addr_i))
	else begin
		$error("bus request dropped or changed before its last beat");
		fail_count++;
	end

	// reader beats neither collide with nor cut into a cache burst
	one_owner: assert property (@(posedge clock) disable iff (reset)
		!(dr_ready_i && (ic_ready_i || ic_open_q)))
	else begin
		$error("reader beat routed during a cache burst");
		fail_count++;
	end

	ready_pulse: assert property (@(posedge clock) disable iff (reset)
		fetch_ready_i |=> !fetch_ready_i)
	else begin
		$error("fetch ready held for two cycles");
		fail_count++;
	end

endmodule

bind fetch_top fetch_props u_fetch_props (
	.clock         (clock),
	.reset         (reset),
	.mem_valid_i   (mem_valid_o),
	.mem_addr_i    (mem_addr_o),
	.mem_ready_i   (mem_ready_i),
	.mem_last_i    (mem_last_i),
	.ic_ready_i    (ic_rsp_ready),
	.dr_ready_i    (dr_rsp_ready),
	.fetch_ready_i (fetch_ready_o)
);

`default_nettype wire

// File: bench/burst_mem.sv
`default_nettype none

module burst_mem (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               mem_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   mem_addr_i,
	input  logic [fetch_pkg::len_width-1:0]    mem_len_i,
	output logic                               mem_ready_o,
	output logic [fetch_pkg::xlen-1:0]         mem_data_o,
	output logic                               mem_last_o
);
	import fetch_pkg::*;

	logic                    active_q;
	logic [addr_width-1:0]   base_q;
	logic [len_width-1:0]    len_q;
	logic [len_width-1:0]    beat_q;
	logic [1:0]              gap_q;  // idle cycles left before the next beat
	logic [31:0]             rng_q;

	function automatic logic [31:0] word_at(input logic [31:0] a);
		return ((a ^ 32'h2545f491) * 32'h9e3779b1) ^ (a >> 13);
	endfunction

	function automatic logic [1:0] next_gap();
		rng_q = rng_q * 32'd1664525 + 32'd1013904223;
		return rng_q[17:16];
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			rng_q = 32'd34;
			active_q    <= 1'b0;
			mem_ready_o <= 1'b0;
			mem_last_o  <= 1'b0;
			mem_data_o  <= '0;
		end else begin
			mem_ready_o <= 1'b0;
			mem_last_o  <= 1'b0;
			if (!active_q) begin
				// the requester still holds valid during its last beat
				if (mem_valid_i && !mem_ready_o) begin
					active_q <= 1'b1;
					base_q   <= mem_addr_i;
					len_q    <= mem_len_i;
					beat_q   <= '0;
					gap_q    <= next_gap();
				end
			end else if (gap_q != 2'd0) begin
				gap_q <= gap_q - 1'b1;
			end else begin
				mem_ready_o <= 1'b1;
				mem_data_o  <= word_at(base_q + {beat_q, 2'b00});
				mem_last_o  <= (beat_q == len_q);
				if (beat_q == len_q) begin
					active_q <= 1'b0;
				end else begin
					beat_q <= beat_q + 1'b1;
					gap_q  <= next_gap();
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`default_nettype none

module fetch_top (
	input  logic                               clock,
	input  logic                               reset,

	input  logic                               fetch_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   fetch_addr_i,
	output logic                               fetch_ready_o,
	output logic [fetch_pkg::xlen-1:0]         fetch_data_o,
	input  logic                               fence_i,

	input  logic                               load_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   load_addr_i,
	output logic                               load_ready_o,
	output logic [fetch_pkg::xlen-1:0]         load_data_o,

	output logic                               mem_valid_o,
	output logic [fetch_pkg::addr_width-1:0]   mem_addr_o,
	output logic [fetch_pkg::len_width-1:0]    mem_len_o,
	input  logic                               mem_ready_i,
	input  logic [fetch_pkg::xlen-1:0]         mem_data_i,
	input  logic                               mem_last_i
);
	import fetch_pkg::*;

	// cache side of the arbiter
	logic                    ic_req_valid;
	logic [addr_width-1:0]   ic_req_addr;
	logic [len_width-1:0]    ic_req_len;
	logic                    ic_rsp_ready;
	logic [xlen-1:0]         ic_rsp_data;
	logic                    ic_rsp_last;

	// reader side of the arbiter
	logic                    dr_req_valid;
	logic [addr_width-1:0]   dr_req_addr;
	logic [len_width-1:0]    dr_req_len;
	logic                    dr_rsp_ready;
	logic [xlen-1:0]         dr_rsp_data;
	logic                    dr_rsp_last;

	icache u_icache (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.fetch_ready_o (fetch_ready_o),
		.fetch_data_o  (fetch_data_o),
		.fence_i       (fence_i),
		.req_valid_o   (ic_req_valid),
		.req_addr_o    (ic_req_addr),
		.req_len_o     (ic_req_len),
		.rsp_ready_i   (ic_rsp_ready),
		.rsp_data_i    (ic_rsp_data),
		.rsp_last_i    (ic_rsp_last)
	);

	dmem_reader u_dmem_reader (
		.clock        (clock),
		.reset        (reset),
		.load_valid_i (load_valid_i),
		.load_addr_i  (load_addr_i),
		.load_ready_o (load_ready_o),
		.load_data_o  (load_data_o),
		.req_valid_o  (dr_req_valid),
		.req_addr_o   (dr_req_addr),
		.req_len_o    (dr_req_len),
		.rsp_ready_i  (dr_rsp_ready),
		.rsp_data_i   (dr_rsp_data),
		.rsp_last_i   (dr_rsp_last)
	);

	read_arbiter u_read_arbiter (
		.clock        (clock),
		.reset        (reset),
		.req0_valid_i (ic_req_valid),
		.req0_addr_i  (ic_req_addr),
		.req0_len_i   (ic_req_len),
		.rsp0_ready_o (ic_rsp_ready),
		.rsp0_data_o  (ic_rsp_data),
		.rsp0_last_o  (ic_rsp_last),
		.req1_valid_i (dr_req_valid),
		.req1_addr_i  (dr_req_addr),
		.req1_len_i   (dr_req_len),
		.rsp1_ready_o (dr_rsp_ready),
		.rsp1_data_o  (dr_rsp_data),
		.rsp1_last_o  (dr_rsp_last),
		.mem_valid_o  (mem_valid_o),
		.mem_addr_o   (mem_addr_o),
		.mem_len_o    (mem_len_o),
		.mem_ready_i  (mem_ready_i),
		.mem_data_i   (mem_data_i),
		.mem_last_i   (mem_last_i)
	);

endmodule

`default_nettype wire

// File: src/read_arbiter.sv
`default_nettype none

module read_arbiter (
	input  logic                               clock,
	input  logic                               reset,

	// peer 0, the instruction cache
	input  logic                               req0_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   req0_addr_i,
	input  logic [fetch_pkg::len_width-1:0]    req0_len_i,
	output logic                               rsp0_ready_o,
	output logic [fetch_pkg::xlen-1:0]         rsp0_data_o,
	output logic                               rsp0_last_o,

	// peer 1, the data reader
	input  logic                               req1_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   req1_addr_i,
	input  logic [fetch_pkg::len_width-1:0]    req1_len_i,
	output logic                               rsp1_ready_o,
	output logic [fetch_pkg::xlen-1:0]         rsp1_data_o,
	output logic                               rsp1_last_o,

	output logic                               mem_valid_o,
	output logic [fetch_pkg::addr_width-1:0]   mem_addr_o,
	output logic [fetch_pkg::len_width-1:0]    mem_len_o,
	input  logic                               mem_ready_i,
	input  logic [fetch_pkg::xlen-1:0]         mem_data_i,
	input  logic                               mem_last_i
);
	import fetch_pkg::*;

	logic busy_q;
	logic owner_q;
	logic rr_q;      // peer favoured on a tie
	logic pick;
	logic sel;
	logic beat;
	logic beat_last;

	always_comb begin
		if (req0_valid_i && req1_valid_i) begin
			pick = rr_q;
		end else begin
			pick = req1_valid_i;  // a lone request wins
		end
	end

	// grant is combinational while free, locked while busy
	assign sel = busy_q ? owner_q : pick;

	assign mem_valid_o = sel ? req1_valid_i : req0_valid_i;
	assign mem_addr_o  = sel ? req1_addr_i : req0_addr_i;
	assign mem_len_o   = sel ? req1_len_i : req0_len_i;

	assign beat      = mem_valid_o && mem_ready_i;
	assign beat_last = beat && mem_last_i;

	assign rsp0_ready_o = beat && !sel;
	assign rsp1_ready_o = beat && sel;
	assign rsp0_last_o  = beat_last && !sel;
	assign rsp1_last_o  = beat_last && sel;
	assign rsp0_data_o  = mem_data_i;
	assign rsp1_data_o  = mem_data_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
			rr_q    <= 1'b0;
		end else if (!busy_q) begin
			if (mem_valid_o) begin
				owner_q <= pick;
				rr_q    <= !pick;
				busy_q  <= !beat_last;  // a one-beat reply may finish at once
			end
		end else if (beat_last) begin
			busy_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/dmem_reader.sv
`default_nettype none

module dmem_reader (
	input  logic                               clock,
	input  logic                               reset,

	input  logic                               load_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   load_addr_i,
	output logic                               load_ready_o,
	output logic [fetch_pkg::xlen-1:0]         load_data_o,

	output logic                               req_valid_o,
	output logic [fetch_pkg::addr_width-1:0]   req_addr_o,
	output logic [fetch_pkg::len_width-1:0]    req_len_o,
	input  logic                               rsp_ready_i,
	input  logic [fetch_pkg::xlen-1:0]         rsp_data_i,
	input  logic                               rsp_last_i
);
	import fetch_pkg::*;

	typedef enum logic {
		idle_s,
		busy_s
	} state_t;

	state_t                  state_q;
	logic [addr_width-1:0]   addr_q;

	always_ff @(posedge clock) begin
		if (state_q == idle_s && load_valid_i) begin
			addr_q <= load_addr_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= idle_s;
		end else if (state_q == idle_s) begin
			if (load_valid_i) state_q <= busy_s;
		end else if (rsp_ready_i && rsp_last_i) begin
			state_q <= idle_s;  // single beat, done
		end
	end

	assign req_valid_o = (state_q == busy_s);
	assign req_addr_o  = addr_q;
	assign req_len_o   = word_burst_len;

	assign load_ready_o = (state_q == busy_s) && rsp_ready_i && rsp_last_i;
	assign load_data_o  = rsp_data_i;  // beat passes straight through

endmodule

`default_nettype wire

// File: src/icache.sv
`default_nettype none

module icache (
	input  logic                               clock,
	input  logic                               reset,

	input  logic                               fetch_valid_i,
	input  logic [fetch_pkg::addr_width-1:0]   fetch_addr_i,
	output logic                               fetch_ready_o,
	output logic [fetch_pkg::xlen-1:0]         fetch_data_o,

	input  logic                               fence_i,

	output logic                               req_valid_o,
	output logic [fetch_pkg::addr_width-1:0]   req_addr_o,
	output logic [fetch_pkg::len_width-1:0]    req_len_o,
	input  logic                               rsp_ready_i,
	input  logic [fetch_pkg::xlen-1:0]         rsp_data_i,
	input  logic                               rsp_last_i
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		idle_s,
		rd_cache_s,
		rd_bus_s,
		fence_s
	} state_t;

	state_t state_q;

	// tag, data and valid storage, one entry per way and set
	logic [tag_bits-1:0]   tag_mem  [way_count][1 << index_bits];
	logic [line_width-1:0] data_mem [way_count][1 << index_bits];
	logic [way_count-1:0]  valid_q  [1 << index_bits];

	// incoming address fields, looked up while idle
	logic [tag_bits-1:0]      in_tag;
	logic [index_bits-1:0]    in_index;
	logic [offset_bits-3:0]   in_word;

	// request captured on acceptance
	logic [tag_bits-1:0]          tag_q;
	logic [index_bits-1:0]        index_q;
	logic [offset_bits-3:0]       word_q;
	logic [$clog2(way_count)-1:0] way_q;

	logic [way_count-1:0]         hit_vec;
	logic                         hit_any;
	logic [$clog2(way_count)-1:0] hit_way;

	logic [$clog2(way_count)-1:0] victim_q;  // free running replacement pointer
	logic [line_width-1:0]        line_q;
	logic [line_width-1:0]        fill_line;
	logic [line_width-1:0]        line_sel;
	logic                         refill_done;

	assign in_tag   = fetch_addr_i[addr_width-1:offset_bits+index_bits];
	assign in_index = fetch_addr_i[offset_bits+index_bits-1:offset_bits];
	assign in_word  = fetch_addr_i[offset_bits-1:2];

	// all ways compared in parallel
	always_comb begin
		for (int w = 0; w < way_count; w++) begin
			hit_vec[w] = valid_q[in_index][w] && (tag_mem[w][in_index] == in_tag);
		end
	end

	// one-hot to way number
	always_comb begin
		hit_any = 1'b0;
		hit_way = '0;
		for (int w = 0; w < way_count; w++) begin
			if (hit_vec[w]) begin
				hit_any = 1'b1;
				hit_way = w[$clog2(way_count)-1:0];
			end
		end
	end

	// beats come in low word first
	assign fill_line   = {rsp_data_i, line_q[line_width-1:xlen]};
	assign refill_done = (state_q == rd_bus_s) && rsp_ready_i && rsp_last_i;

	always_ff @(posedge clock) begin
		if (state_q == idle_s && fetch_valid_i) begin
			tag_q   <= in_tag;
			index_q <= in_index;
			word_q  <= in_word;
			way_q   <= hit_way;
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == rd_bus_s && rsp_ready_i) begin
			line_q <= fill_line;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			victim_q <= '0;
		end else begin
			victim_q <= victim_q + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (refill_done) begin
			tag_mem[victim_q][index_q]  <= tag_q;
			data_mem[victim_q][index_q] <= fill_line;
		end
	end

	// fence wipes the whole cache in one edge
	always_ff @(posedge clock) begin
		if (reset || fence_i) begin
			for (int s = 0; s < (1 << index_bits); s++) begin
				valid_q[s] <= '0;
			end
		end else if (refill_done) begin
			valid_q[index_q][victim_q] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= idle_s;
		end else begin
			case (state_q)
				idle_s: begin
					if (fetch_valid_i) begin
						state_q <= hit_any ? rd_cache_s : rd_bus_s;
					end else if (fence_i) begin
						state_q <= fence_s;
					end
				end
				rd_cache_s: state_q <= idle_s;
				rd_bus_s: begin
					if (rsp_ready_i && rsp_last_i) begin
						state_q <= idle_s;
					end
				end
				default: state_q <= idle_s;  // fence_s lasts one cycle
			endcase
		end
	end

	// on a miss the word comes from the line being assembled
	assign line_sel      = (state_q == rd_bus_s) ? fill_line : data_mem[way_q][index_q];
	assign fetch_data_o  = line_sel[word_q*xlen +: xlen];
	assign fetch_ready_o = (state_q == rd_cache_s) || refill_done;

	assign req_valid_o = (state_q == rd_bus_s);
	assign req_addr_o  = {tag_q, index_q, {offset_bits{1'b0}}};
	assign req_len_o   = line_burst_len;

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// word and address widths
	localparam int xlen = 32;
	localparam int addr_width = 32;

	// cache geometry
	localparam int offset_bits = 4;  // 16 byte lines
	localparam int index_bits = 8;   // 256 sets
	localparam int tag_bits = addr_width - index_bits - offset_bits;
	localparam int way_count = 4;
	localparam int line_width = 8 << offset_bits;

	// burst length codes, beats minus one
	localparam int len_width = 8;
	localparam logic [len_width-1:0] line_burst_len = len_width'(3);
	localparam logic [len_width-1:0] word_burst_len = len_width'(0);

endpackage

`default_nettype wire
